// File: logic/icache_pkg.sv
package icache_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // 32-byte lines, eight words each
  localparam int OFFSET_BITS = 5;
  localparam int WORDS_PER_LINE = 8;
  localparam int NUM_WAYS = 4;

  typedef word_t [WORDS_PER_LINE-1:0] line_t;

  // tree pseudo-LRU, the bits point at the next victim
  // bit 2: 1 picks ways 0/1, 0 picks ways 2/3
  // bit 1: 1 picks way 0, 0 picks way 1
  // bit 0: 1 picks way 2, 0 picks way 3
  typedef logic [2:0] lru_t;

  // address fed to the arrays
  typedef enum logic
  {
    curr_addr,
    held_addr
  } addr_sel_t;

  // source of a data array write
  typedef enum logic
  {
    no_fill,
    fill_from_mem
  } fill_sel_t;

  // registered lookup result, one per cycle
  typedef struct packed
  {
    addr_t addr;
    logic hit;
    logic [NUM_WAYS-1:0] hit_way;
    logic [NUM_WAYS-1:0] valid;
    lru_t lru;
  } stage_t;

endpackage : icache_pkg

// File: logic/icache_stage_if.sv
`timescale 1ns/1ps

interface icache_stage_if;
  import icache_pkg::*;

  // lookup result of the previous cycle
  stage_t rec;

  // commands from the controller
  addr_sel_t addr_sel;
  fill_sel_t fill_sel;
  logic [NUM_WAYS-1:0] way_fill;
  logic lru_load;
  lru_t lru_data;

  modport lookup (
    output rec,
    input  addr_sel,
    input  fill_sel,
    input  way_fill,
    input  lru_load,
    input  lru_data
  );

  modport control (
    input  rec,
    output addr_sel,
    output fill_sel,
    output way_fill,
    output lru_load,
    output lru_data
  );

endinterface : icache_stage_if

// File: logic/icache_array.sv
`timescale 1ns/1ps

module icache_array #(
  parameter int SET_BITS = 3,
  parameter type payload_t = logic,
  parameter bit CLEARED = 1'b0
) (
  input  logic clk,
  input  logic rst,
  input  logic load,
  input  logic [SET_BITS-1:0] index,
  input  payload_t datain,
  output payload_t dataout
);

  localparam int SETS = 1 << SET_BITS;

  payload_t mem [SETS];

  // read is combinational, the stage register samples it
  assign dataout = mem[index];

  always_ff @(posedge clk)
  begin
    if (CLEARED && rst)
    begin
      for (int i = 0; i < SETS; i++)
      begin
        mem[i] <= '0;
      end
    end
    else if (load)
    begin
      mem[index] <= datain;
    end
  end

endmodule : icache_array

// File: logic/icache_lookup.sv
`timescale 1ns/1ps

module icache_lookup #(
  parameter int SET_BITS = 3
) (
  input  logic clk,
  input  logic rst,
  input  icache_pkg::addr_t mem_address,
  output icache_pkg::word_t mem_rdata,
  input  icache_pkg::line_t pmem_rdata,
  output icache_pkg::addr_t pmem_address,
  icache_stage_if.lookup stage
);
  import icache_pkg::*;

  localparam int TAG_BITS = 32 - SET_BITS - OFFSET_BITS;

  typedef logic [TAG_BITS-1:0] tag_t;

  addr_t look_addr;
  logic [SET_BITS-1:0] look_set;
  logic [SET_BITS-1:0] held_set;
  logic [SET_BITS-1:0] lru_idx;
  tag_t look_tag;
  tag_t held_tag;

  tag_t tag_out [NUM_WAYS];
  line_t data_out [NUM_WAYS];
  logic [NUM_WAYS-1:0] valid_out;
  logic [NUM_WAYS-1:0] match;
  lru_t lru_out;

  stage_t rec_d;
  stage_t rec_q;
  line_t hit_line;

  assign look_addr = (stage.addr_sel == held_addr) ? rec_q.addr : mem_address;
  assign look_set = look_addr[OFFSET_BITS +: SET_BITS];
  assign look_tag = look_addr[31 -: TAG_BITS];
  assign held_set = rec_q.addr[OFFSET_BITS +: SET_BITS];
  assign held_tag = rec_q.addr[31 -: TAG_BITS];

  for (genvar w = 0; w < NUM_WAYS; w++)
  begin : g_way
    logic [SET_BITS-1:0] meta_idx;
    logic data_load;

    // writes go to the set of the staged request
    assign meta_idx = stage.way_fill[w] ? held_set : look_set;
    assign data_load = stage.way_fill[w] && (stage.fill_sel == fill_from_mem);

    icache_array #(.SET_BITS(SET_BITS), .payload_t(tag_t)) tag_array (
      .clk     (clk),
      .rst     (rst),
      .load    (stage.way_fill[w]),
      .index   (meta_idx),
      .datain  (held_tag),
      .dataout (tag_out[w])
    );

    icache_array #(.SET_BITS(SET_BITS), .payload_t(logic), .CLEARED(1'b1)) valid_array (
      .clk     (clk),
      .rst     (rst),
      .load    (stage.way_fill[w]),
      .index   (meta_idx),
      .datain  (1'b1),
      .dataout (valid_out[w])
    );

    // data is only read for the staged request
    icache_array #(.SET_BITS(SET_BITS), .payload_t(line_t)) data_array (
      .clk     (clk),
      .rst     (rst),
      .load    (data_load),
      .index   (held_set),
      .datain  (pmem_rdata),
      .dataout (data_out[w])
    );

    assign match[w] = valid_out[w] && (tag_out[w] == look_tag);
  end

  assign lru_idx = stage.lru_load ? held_set : look_set;

  icache_array #(.SET_BITS(SET_BITS), .payload_t(lru_t), .CLEARED(1'b1)) lru_array (
    .clk     (clk),
    .rst     (rst),
    .load    (stage.lru_load),
    .index   (lru_idx),
    .datain  (stage.lru_data),
    .dataout (lru_out)
  );

  always_comb
  begin
    rec_d.addr = look_addr;
    rec_d.hit = |match;
    rec_d.hit_way = match;
    rec_d.valid = valid_out;
    rec_d.lru = lru_out;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      rec_q <= '0;
    else
      rec_q <= rec_d;
  end

  assign stage.rec = rec_q;

  // hit_way is one-hot, so an OR of the masked lines is the hit line
  always_comb
  begin
    hit_line = '0;
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      if (rec_q.hit_way[w])
        hit_line = hit_line | data_out[w];
    end
  end

  assign mem_rdata = hit_line[rec_q.addr[OFFSET_BITS-1:2]];
  assign pmem_address = {rec_q.addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

endmodule : icache_lookup

// File: logic/icache_control.sv
`timescale 1ns/1ps

module icache_control (
  input  logic clk,
  input  logic rst,
  input  logic mem_read,
  output logic mem_resp,
  input  logic pmem_resp,
  output logic pmem_read,
  icache_stage_if.control stage
);
  import icache_pkg::*;

  // START idle, MISS evaluates the record and waits on memory,
  // HIT is the cycle after a response or a fill
  typedef enum logic [1:0]
  {
    START,
    MISS,
    HIT
  } state_t;

  state_t state;
  state_t next_state;

  logic [NUM_WAYS-1:0] victim;
  lru_t lru_next;

  // lowest invalid way first, then the tree victim
  always_comb
  begin
    victim = '0;
    if (!stage.rec.valid[0])
      victim[0] = 1'b1;
    else if (!stage.rec.valid[1])
      victim[1] = 1'b1;
    else if (!stage.rec.valid[2])
      victim[2] = 1'b1;
    else if (!stage.rec.valid[3])
      victim[3] = 1'b1;
    else if (!stage.rec.lru[2])
    begin
      if (stage.rec.lru[0])
        victim[2] = 1'b1;
      else
        victim[3] = 1'b1;
    end
    else
    begin
      if (stage.rec.lru[1])
        victim[0] = 1'b1;
      else
        victim[1] = 1'b1;
    end
  end

  // point away from the hit way, the other pair keeps its bit
  always_comb
  begin
    lru_next = stage.rec.lru;
    if (stage.rec.hit_way[0])
      lru_next = {1'b0, 1'b0, stage.rec.lru[0]};
    else if (stage.rec.hit_way[1])
      lru_next = {1'b0, 1'b1, stage.rec.lru[0]};
    else if (stage.rec.hit_way[2])
      lru_next = {1'b1, stage.rec.lru[1], 1'b0};
    else if (stage.rec.hit_way[3])
      lru_next = {1'b1, stage.rec.lru[1], 1'b1};
  end

  always_comb
  begin
    mem_resp = 1'b0;
    pmem_read = 1'b0;
    stage.addr_sel = curr_addr;
    stage.fill_sel = no_fill;
    stage.way_fill = '0;
    stage.lru_load = 1'b0;
    stage.lru_data = lru_next;
    next_state = state;

    case (state)
      START:
      begin
        if (mem_read)
          next_state = MISS;
      end

      MISS:
      begin
        stage.addr_sel = held_addr;
        if (!mem_read)
          next_state = START;
        else if (stage.rec.hit)
        begin
          mem_resp = 1'b1;
          stage.lru_load = 1'b1;
          // let the next cpu address reach the arrays
          stage.addr_sel = curr_addr;
          next_state = HIT;
        end
        else
        begin
          pmem_read = 1'b1;
          if (pmem_resp)
          begin
            stage.way_fill = victim;
            stage.fill_sel = fill_from_mem;
            next_state = HIT;
          end
        end
      end

      HIT:
      begin
        // record is one cycle stale here, look up the cpu address again
        if (mem_read)
          next_state = MISS;
        else
          next_state = START;
      end

      default:
      begin
        next_state = START;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= START;
    else
      state <= next_state;
  end

endmodule : icache_control

// File: logic/icache_top.sv
`timescale 1ns/1ps

module icache_top #(
  parameter int SET_BITS = 3
) (
  input  logic clk,
  input  logic rst,

  // cpu side
  input  logic mem_read,
  input  icache_pkg::addr_t mem_address,
  output logic mem_resp,
  output icache_pkg::word_t mem_rdata,

  // physical memory side
  output logic pmem_read,
  output icache_pkg::addr_t pmem_address,
  input  logic pmem_resp,
  input  icache_pkg::line_t pmem_rdata
);

  icache_stage_if stage_bus ();

  icache_lookup #(
    .SET_BITS (SET_BITS)
  ) u_lookup (
    .clk          (clk),
    .rst          (rst),
    .mem_address  (mem_address),
    .mem_rdata    (mem_rdata),
    .pmem_rdata   (pmem_rdata),
    .pmem_address (pmem_address),
    .stage        (stage_bus.lookup)
  );

  icache_control u_control (
    .clk       (clk),
    .rst       (rst),
    .mem_read  (mem_read),
    .mem_resp  (mem_resp),
    .pmem_resp (pmem_resp),
    .pmem_read (pmem_read),
    .stage     (stage_bus.control)
  );

endmodule : icache_top

// File: tests/icache_model.sv
`timescale 1ns/1ps

module icache_model #(
  parameter int SET_BITS = 3,
  parameter int SEED = 1
) (
  input  logic clk,
  input  logic pmem_read,
  input  icache_pkg::addr_t pmem_address,
  output logic pmem_resp,
  output icache_pkg::line_t pmem_rdata
);
  import icache_pkg::*;

  localparam int SETS = 1 << SET_BITS;

  // way w of set s sits at s*NUM_WAYS+w
  addr_t tags [SETS*NUM_WAYS];
  bit valid [SETS*NUM_WAYS];
  lru_t lru [SETS];
  int evictions = 0;
  int unsigned delay_state = SEED;
  int delay;
  line_t line;

  // memory contents, a hash of the line address and the word index
  function automatic word_t line_word(addr_t addr);
    word_t h;
    h = (addr >> OFFSET_BITS) * 32'h9e37_79b1;
    h = h ^ ({29'd0, addr[4:2]} * 32'h85eb_ca6b);
    return h ^ (h >> 15);
  endfunction

  function automatic int next_delay();
    delay_state = delay_state * 32'd1664525 + 32'd1013904223;
    return 1 + int'(delay_state[31:24] % 6);
  endfunction

  task automatic clear();
    for (int i = 0; i < SETS*NUM_WAYS; i++)
      valid[i] = 1'b0;
    for (int s = 0; s < SETS; s++)
      lru[s] = '0;
  endtask

  // tree points away from the way just used
  function automatic void touch(int set, int way);
    if (way < 2)
    begin
      lru[set][2] = 1'b0;
      lru[set][1] = (way == 1);
    end
    else
    begin
      lru[set][2] = 1'b1;
      lru[set][0] = (way == 3);
    end
  endfunction

  function automatic int pick_victim(int set);
    int way;
    way = -1;
    for (int w = NUM_WAYS - 1; w >= 0; w--)
      if (!valid[set*NUM_WAYS + w])
        way = w;
    if (way < 0)
    begin
      evictions++;
      if (lru[set][2])
        way = lru[set][1] ? 0 : 1;
      else
        way = lru[set][0] ? 2 : 3;
    end
    return way;
  endfunction

  // returns the predicted hit and updates the copy
  function automatic bit access(addr_t addr);
    int set;
    int way;
    addr_t tag;
    set = addr[OFFSET_BITS +: SET_BITS];
    tag = addr >> (OFFSET_BITS + SET_BITS);
    way = -1;
    for (int w = 0; w < NUM_WAYS; w++)
      if (valid[set*NUM_WAYS + w] && tags[set*NUM_WAYS + w] == tag)
        way = w;
    if (way >= 0)
    begin
      touch(set, way);
      return 1'b1;
    end
    way = pick_victim(set);
    valid[set*NUM_WAYS + way] = 1'b1;
    tags[set*NUM_WAYS + way] = tag;
    // the refill ends in a hit on the same way
    touch(set, way);
    return 1'b0;
  endfunction

  // memory responder, one line per request after 1 to 6 cycles
  initial
  begin
    pmem_resp = 1'b0;
    pmem_rdata = '0;
    forever
    begin
      @(negedge clk);
      if (pmem_read)
      begin
        delay = next_delay();
        repeat (delay) @(negedge clk);
        for (int i = 0; i < WORDS_PER_LINE; i++)
          line[i] = line_word(pmem_address | (i << 2));
        pmem_rdata = line;
        pmem_resp = 1'b1;
        @(negedge clk);
        pmem_resp = 1'b0;
      end
    end
  end

endmodule : icache_model

// File: tests/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;
  import icache_pkg::*;

  localparam int SET_BITS = 3;
  localparam int SEED = 18496;
  localparam int RESP_TIMEOUT = 20;
  localparam int POOL_TAGS = 6;

  logic clk;
  logic rst;
  logic mem_read;
  addr_t mem_address;
  logic mem_resp;
  word_t mem_rdata;
  logic pmem_read;
  addr_t pmem_address;
  logic pmem_resp;
  line_t pmem_rdata;

  int unsigned lcg_state;
  int cycle = 0;
  int fills = 0;
  int fill_cycle = 0;
  int hits = 0;
  int misses = 0;

  icache_top #(.SET_BITS(SET_BITS)) DUT (
    .clk          (clk),
    .rst          (rst),
    .mem_read     (mem_read),
    .mem_address  (mem_address),
    .mem_resp     (mem_resp),
    .mem_rdata    (mem_rdata),
    .pmem_read    (pmem_read),
    .pmem_address (pmem_address),
    .pmem_resp    (pmem_resp),
    .pmem_rdata   (pmem_rdata)
  );

  icache_model #(.SET_BITS(SET_BITS), .SEED(SEED)) model (
    .clk          (clk),
    .pmem_read    (pmem_read),
    .pmem_address (pmem_address),
    .pmem_resp    (pmem_resp),
    .pmem_rdata   (pmem_rdata)
  );

  always #4 clk = ~clk;

  // cycle count and the cycle of each memory response
  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (pmem_resp)
    begin
      fills <= fills + 1;
      fill_cycle <= cycle;
    end
  end

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("FAILED time=%0t signal=%s expected=%h actual=%h",
               $time, name, expected, actual);
      stop_run();
    end
  endtask

  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  // mostly six tags in sets 1 and 5 and now and then any word address
  function automatic addr_t pick_address();
    logic [15:0] r;
    addr_t tag;
    addr_t set;
    r = next_rand();
    if (r[15:13] == 3'd0)
      return {next_rand(), next_rand()} & 32'hffff_fffc;
    tag = 32'h80 + (r[7:0] % POOL_TAGS) * 32'h11;
    set = r[8] ? 32'd1 : 32'd5;
    return (tag << (OFFSET_BITS + SET_BITS)) | (set << OFFSET_BITS) | {27'd0, r[11:9], 2'b00};
  endfunction

  task automatic apply_reset();
    rst = 1'b1;
    mem_read = 1'b0;
    model.clear();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic idle_cycles(input int count);
    repeat (count)
    begin
      @(negedge clk);
      check_value("mem_resp", 0, mem_resp);
      check_value("pmem_read", 0, pmem_read);
      mem_read = 1'b0;
    end
  endtask

  task automatic run_request(input addr_t addr);
    bit exp_hit;
    word_t exp_word;
    int start;
    int fills_before;
    int first_pmem;
    int waited;
    bit done;
    exp_hit = model.access(addr);
    exp_word = model.line_word(addr);
    @(negedge clk);
    mem_read = 1'b1;
    mem_address = addr;
    start = cycle;
    fills_before = fills;
    first_pmem = -1;
    waited = 0;
    done = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      waited++;
      if (pmem_read && first_pmem < 0)
      begin
        first_pmem = cycle;
        check_value("pmem_address", addr & 32'hffff_ffe0, pmem_address);
      end
      // the line request stays up until memory answers
      if (first_pmem >= 0 && fills == fills_before)
        check_value("pmem_read", 1, pmem_read);
      if (mem_resp)
        done = 1'b1;
      else if (waited >= RESP_TIMEOUT)
      begin
        $display("timeout: no mem_resp within %0d cycles for address %h", RESP_TIMEOUT, addr);
        stop_run();
      end
    end
    check_value("pmem_read", !exp_hit, first_pmem >= 0);
    if (exp_hit)
    begin
      hits++;
      check_value("mem_resp cycle", start + 1, cycle);
      check_value("pmem_resp count", fills_before, fills);
    end
    else
    begin
      misses++;
      check_value("pmem_read cycle", start + 1, first_pmem);
      check_value("pmem_resp count", fills_before + 1, fills);
      check_value("mem_resp cycle", fill_cycle + 2, cycle);
    end
    check_value("mem_rdata", exp_word, mem_rdata);
  endtask

  // back-to-back requests with an occasional idle gap
  task automatic run_phase(input int count);
    logic [15:0] r;
    for (int i = 0; i < count; i++)
    begin
      r = next_rand();
      if (r[2:0] == 3'd0)
        idle_cycles(1 + r[4:3]);
      run_request(pick_address());
    end
  endtask

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    mem_read = 1'b0;
    mem_address = '0;
    lcg_state = SEED;
    apply_reset();
    idle_cycles(4);
    run_phase(400);
    // second reset must leave every line invalid again
    apply_reset();
    idle_cycles(4);
    run_phase(150);
    assert (hits > 0 && misses > 0 && model.evictions > 0)
    begin
      $display("Simulation completed successfully");
      $finish;
    end
    else
    begin
      $display("error: the run produced no hits, no misses or no evictions");
      stop_run();
    end
  end

endmodule : icache_tb

// File: tb.f
logic/icache_pkg.sv
logic/icache_stage_if.sv
logic/icache_array.sv
logic/icache_lookup.sv
logic/icache_control.sv
logic/icache_top.sv
tests/icache_model.sv
tests/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - logic/icache_pkg.sv
  - logic/icache_stage_if.sv
  - logic/icache_array.sv
  - logic/icache_lookup.sv
  - logic/icache_control.sv
  - logic/icache_top.sv
  - target: test
    files:
      - tests/icache_model.sv
      - tests/icache_tb.sv
